/* verilog/core_pkg.sv */
/*
 Shared widths and encodings for the integer pipeline slice
 Operand select codes run RF, IMM, EX forward, WB forward
 Operand A never selects the immediate
*/
package core_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	// Default datapath width
	localparam int WIDTH = 32;

	// Default register index width for 32 registers
	localparam int REG_ADDR_W = 5;

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////

	// ALU function of each instruction
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_SLL = 3'd5,
		OP_SRL = 3'd6
	} alu_op_e;

	// Operand source in the ID stage
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} opsel_e;

endpackage

/* verilog/fwd_if.sv */
/*
 EX and WB stage state shared by the forwarding logic
 All signals are driven by the execute unit
 ex_result is combinational, the rest come from flops
*/
`timescale 1ns/1ps

interface fwd_if #(
	parameter int WIDTH      = core_pkg::WIDTH,
	parameter int REG_ADDR_W = core_pkg::REG_ADDR_W
);

	// EX stage
	logic                  ex_valid;
	logic [REG_ADDR_W-1:0] ex_rd;
	logic [WIDTH-1:0]      ex_result;

	// WB stage
	logic                  wb_valid;
	logic [REG_ADDR_W-1:0] wb_rd;
	logic [WIDTH-1:0]      wb_result;

	// Producer side
	modport exec (output ex_valid, ex_rd, ex_result, wb_valid, wb_rd, wb_result);

	// Hazard compare, indices only
	modport sel (input ex_valid, ex_rd, wb_valid, wb_rd);

	// Forwarded data
	modport mux (input ex_result, wb_result);

	// Register file write port
	modport rf (input wb_valid, wb_rd, wb_result);

endinterface

/* verilog/reg_file.sv */
/*
 Two read ports, one write port from the WB stage
 Reads are combinational, writes land on the edge ending WB
 r0 always reads zero and is never written
*/
`timescale 1ns/1ps

module reg_file #(
	parameter int WIDTH      = core_pkg::WIDTH,
	parameter int REG_ADDR_W = core_pkg::REG_ADDR_W
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] ra,
	input  logic [REG_ADDR_W-1:0] rb,
	output logic [WIDTH-1:0]      rf_a,
	output logic [WIDTH-1:0]      rf_b,
	fwd_if.rf                     fwd
);

	localparam int DEPTH = 1 << REG_ADDR_W;

	// Register storage
	logic [WIDTH-1:0] regs [DEPTH];

	// Write strobe, r0 excluded
	logic we;

	assign we = fwd.wb_valid && (fwd.wb_rd != '0);

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	// Whole array cleared by reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[fwd.wb_rd] <= fwd.wb_result;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////

	// r0 forced to zero on both ports
	assign rf_a = (ra == '0) ? '0 : regs[ra];
	assign rf_b = (rb == '0) ? '0 : regs[rb];

	// r0 storage stays clear however WB addresses it
	a_r0_clear: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> regs[0] == '0)
		else $error("reg_file: r0 was written");

endmodule

/* verilog/fwd_select.sv */
/*
 Operand source selection for the instruction in ID
 EX wins over WB, a destination of r0 never matches
 The immediate overrides forwarding on operand B
*/
`timescale 1ns/1ps

module fwd_select #(
	parameter int REG_ADDR_W = core_pkg::REG_ADDR_W
) (
	input  logic                  issue,
	input  logic [REG_ADDR_W-1:0] ra,
	input  logic [REG_ADDR_W-1:0] rb,
	input  logic                  use_imm,
	output core_pkg::opsel_e      sel_a,
	output core_pkg::opsel_e      sel_b,
	fwd_if.sel                    fwd
);

	import core_pkg::*;

	// Stage holds a result that can be forwarded
	logic ex_live;
	logic wb_live;

	// Per operand hits
	logic a_ex_hit;
	logic a_wb_hit;
	logic b_ex_hit;
	logic b_wb_hit;

	assign ex_live = fwd.ex_valid && (fwd.ex_rd != '0);
	assign wb_live = fwd.wb_valid && (fwd.wb_rd != '0);

	// Only an issuing instruction looks for hazards
	assign a_ex_hit = issue && ex_live && (ra == fwd.ex_rd);
	assign a_wb_hit = issue && wb_live && (ra == fwd.wb_rd);
	assign b_ex_hit = issue && ex_live && (rb == fwd.ex_rd);
	assign b_wb_hit = issue && wb_live && (rb == fwd.wb_rd);

	always_comb begin
		// Operand A, younger stage first
		if (a_ex_hit)
			sel_a = SEL_EX_FORW;
		else if (a_wb_hit)
			sel_a = SEL_WB_FORW;
		else
			sel_a = SEL_RF;

		// Operand B, immediate before any forward
		if (issue && use_imm)
			sel_b = SEL_IMM;
		else if (b_ex_hit)
			sel_b = SEL_EX_FORW;
		else if (b_wb_hit)
			sel_b = SEL_WB_FORW;
		else
			sel_b = SEL_RF;
	end

	// Operand A has no immediate path in the mux
	always_comb begin
		assert (sel_a != SEL_IMM)
			else $error("fwd_select: operand A selected the immediate");
	end

endmodule

/* verilog/operand_muxes.sv */
/*
 Operand A and B source muxes and their operand registers
 Registers load on issue and hold through bubbles
 Selects must come from fwd_select in the same cycle as issue
*/
`timescale 1ns/1ps

module operand_muxes #(
	parameter int WIDTH = core_pkg::WIDTH
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             issue,
	input  logic [WIDTH-1:0] rf_a,
	input  logic [WIDTH-1:0] rf_b,
	input  logic [WIDTH-1:0] imm,
	input  core_pkg::opsel_e sel_a,
	input  core_pkg::opsel_e sel_b,
	output logic [WIDTH-1:0] operand_a,
	output logic [WIDTH-1:0] operand_b,
	fwd_if.mux               fwd
);

	import core_pkg::*;

	// Selected sources ahead of the registers
	logic [WIDTH-1:0] muxed_a;
	logic [WIDTH-1:0] muxed_b;

	////////////////////////////////////////
	// Source muxes
	////////////////////////////////////////

	// Operand A from the RF unless forwarded
	always_comb begin
		case (sel_a)
			SEL_EX_FORW: muxed_a = fwd.ex_result;
			SEL_WB_FORW: muxed_a = fwd.wb_result;
			default:     muxed_a = rf_a;
		endcase
	end

	// Operand B adds the immediate
	always_comb begin
		case (sel_b)
			SEL_IMM:     muxed_b = imm;
			SEL_EX_FORW: muxed_b = fwd.ex_result;
			SEL_WB_FORW: muxed_b = fwd.wb_result;
			default:     muxed_b = rf_b;
		endcase
	end

	////////////////////////////////////////
	// Operand registers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			operand_a <= '0;
			operand_b <= '0;
		end else if (issue) begin
			operand_a <= muxed_a;
			operand_b <= muxed_b;
		end
	end

	// Registered value matches the source picked last cycle
	a_a_ex: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n && issue && sel_a == SEL_EX_FORW)
		|-> operand_a == $past(fwd.ex_result));
	a_a_wb: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n && issue && sel_a == SEL_WB_FORW)
		|-> operand_a == $past(fwd.wb_result));
	a_b_imm: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n && issue && sel_b == SEL_IMM)
		|-> operand_b == $past(imm));
	a_b_rf: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n && issue && sel_b == SEL_RF)
		|-> operand_b == $past(rf_b));

endmodule

/* verilog/exec_unit.sv */
/*
 EX stage ALU and WB result register
 Results leave exactly two cycles after the issue edge
 Shifts use the low five bits of operand B, add and sub wrap
*/
`timescale 1ns/1ps

module exec_unit #(
	parameter int WIDTH      = core_pkg::WIDTH,
	parameter int REG_ADDR_W = core_pkg::REG_ADDR_W
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  issue,
	input  core_pkg::alu_op_e     op,
	input  logic [REG_ADDR_W-1:0] rd,
	input  logic [WIDTH-1:0]      operand_a,
	input  logic [WIDTH-1:0]      operand_b,
	fwd_if.exec                   fwd,
	output logic                  res_valid,
	output logic [REG_ADDR_W-1:0] res_rd,
	output logic [WIDTH-1:0]      res_data
);

	import core_pkg::*;

	// EX stage control
	logic                  ex_valid_q;
	logic [REG_ADDR_W-1:0] ex_rd_q;
	alu_op_e               ex_op_q;

	// ALU
	logic [4:0]       shamt;
	logic [WIDTH-1:0] alu_out;

	// WB stage
	logic                  wb_valid_q;
	logic [REG_ADDR_W-1:0] wb_rd_q;
	logic [WIDTH-1:0]      wb_result_q;

	////////////////////////////////////////
	// EX stage
	////////////////////////////////////////

	// Captured alongside the operand registers
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid_q <= 1'b0;
			ex_rd_q    <= '0;
			ex_op_q    <= OP_ADD;
		end else begin
			ex_valid_q <= issue;
			if (issue) begin
				ex_rd_q <= rd;
				ex_op_q <= op;
			end
		end
	end

	assign shamt = operand_b[4:0];

	always_comb begin
		case (ex_op_q)
			OP_ADD:  alu_out = operand_a + operand_b;
			OP_SUB:  alu_out = operand_a - operand_b;
			OP_AND:  alu_out = operand_a & operand_b;
			OP_OR:   alu_out = operand_a | operand_b;
			OP_XOR:  alu_out = operand_a ^ operand_b;
			OP_SLL:  alu_out = operand_a << shamt;
			OP_SRL:  alu_out = operand_a >> shamt;
			default: alu_out = '0;
		endcase
	end

	////////////////////////////////////////
	// WB stage
	////////////////////////////////////////

	// Result held for one writeback cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid_q  <= 1'b0;
			wb_rd_q     <= '0;
			wb_result_q <= '0;
		end else begin
			wb_valid_q <= ex_valid_q;
			if (ex_valid_q) begin
				wb_rd_q     <= ex_rd_q;
				wb_result_q <= alu_out;
			end
		end
	end

	// Stage state to the forwarding logic and register file
	assign fwd.ex_valid  = ex_valid_q;
	assign fwd.ex_rd     = ex_rd_q;
	assign fwd.ex_result = alu_out;
	assign fwd.wb_valid  = wb_valid_q;
	assign fwd.wb_rd     = wb_rd_q;
	assign fwd.wb_result = wb_result_q;

	assign res_valid = wb_valid_q;
	assign res_rd    = wb_rd_q;
	assign res_data  = wb_result_q;

	// Fixed two cycle latency, no lost or extra results
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		issue |-> ##2 (res_valid && res_rd == $past(rd, 2)));
	a_no_ghost: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> $past(issue, 2));

endmodule

/* verilog/pipe_top.sv */
/*
 Integer pipeline slice, ID / EX / WB
 One instruction per issue strobe, no back-pressure, no stalls
 Results appear two cycles after issue on res_*
*/
`timescale 1ns/1ps

module pipe_top #(
	parameter int WIDTH      = core_pkg::WIDTH,
	parameter int REG_ADDR_W = core_pkg::REG_ADDR_W
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  issue,
	input  core_pkg::alu_op_e     op,
	input  logic [REG_ADDR_W-1:0] rd,
	input  logic [REG_ADDR_W-1:0] ra,
	input  logic [REG_ADDR_W-1:0] rb,
	input  logic [WIDTH-1:0]      imm,
	input  logic                  use_imm,
	output logic                  res_valid,
	output logic [REG_ADDR_W-1:0] res_rd,
	output logic [WIDTH-1:0]      res_data
);

	import core_pkg::*;

	// ID stage data
	logic [WIDTH-1:0] rf_a;
	logic [WIDTH-1:0] rf_b;
	opsel_e           sel_a;
	opsel_e           sel_b;

	// EX stage operands
	logic [WIDTH-1:0] operand_a;
	logic [WIDTH-1:0] operand_b;

	// Stage state bundle
	fwd_if #(.WIDTH(WIDTH), .REG_ADDR_W(REG_ADDR_W)) u_fwd ();

	reg_file #(.WIDTH(WIDTH), .REG_ADDR_W(REG_ADDR_W)) u_reg_file (
		.clk  (clk),
		.rst_n(rst_n),
		.ra   (ra),
		.rb   (rb),
		.rf_a (rf_a),
		.rf_b (rf_b),
		.fwd  (u_fwd.rf)
	);

	fwd_select #(.REG_ADDR_W(REG_ADDR_W)) u_fwd_select (
		.issue  (issue),
		.ra     (ra),
		.rb     (rb),
		.use_imm(use_imm),
		.sel_a  (sel_a),
		.sel_b  (sel_b),
		.fwd    (u_fwd.sel)
	);

	operand_muxes #(.WIDTH(WIDTH)) u_operand_muxes (
		.clk      (clk),
		.rst_n    (rst_n),
		.issue    (issue),
		.rf_a     (rf_a),
		.rf_b     (rf_b),
		.imm      (imm),
		.sel_a    (sel_a),
		.sel_b    (sel_b),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.fwd      (u_fwd.mux)
	);

	exec_unit #(.WIDTH(WIDTH), .REG_ADDR_W(REG_ADDR_W)) u_exec_unit (
		.clk      (clk),
		.rst_n    (rst_n),
		.issue    (issue),
		.op       (op),
		.rd       (rd),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.fwd      (u_fwd.exec),
		.res_valid(res_valid),
		.res_rd   (res_rd),
		.res_data (res_data)
	);

endmodule

/* testbench/tb_pipe.sv */
/*
 Testbench for pipe_top, directed table followed by an LFSR stream
 Expected results come from a register model updated in issue order
 Results are checked two cycles after issue, at the falling edge
*/
`timescale 1ns/1ps

module tb_pipe;

	import core_pkg::*;

	localparam int    TB_WIDTH      = core_pkg::WIDTH;
	localparam int    TB_ADDR_W     = core_pkg::REG_ADDR_W;
	localparam int    CLK_PERIOD    = 40;
	localparam int    RESET_CYCLES  = 10;
	localparam int    RANDOM_ROWS   = 400;
	localparam int    MARGIN_CYCLES = 50;
	localparam [31:0] LFSR_SEED     = 32'he27ad838;

	logic                 clk;
	logic                 rst_n;
	logic                 issue;
	alu_op_e              op;
	logic [TB_ADDR_W-1:0] rd;
	logic [TB_ADDR_W-1:0] ra;
	logic [TB_ADDR_W-1:0] rb;
	logic [TB_WIDTH-1:0]  imm;
	logic                 use_imm;
	logic                 res_valid;
	logic [TB_ADDR_W-1:0] res_rd;
	logic [TB_WIDTH-1:0]  res_data;

	// Stimulus table, one entry per cycle
	logic                 t_issue[$];
	alu_op_e              t_op[$];
	logic [TB_ADDR_W-1:0] t_rd[$];
	logic [TB_ADDR_W-1:0] t_ra[$];
	logic [TB_ADDR_W-1:0] t_rb[$];
	logic [TB_WIDTH-1:0]  t_imm[$];
	logic                 t_use_imm[$];
	string                t_name[$];

	// Expected results in flight, bubbles included
	logic                 exp_valid_q[$];
	logic [TB_ADDR_W-1:0] exp_rd_q[$];
	logic [TB_WIDTH-1:0]  exp_data_q[$];
	string                exp_name_q[$];

	// Architectural register model
	logic [TB_WIDTH-1:0] model [1 << TB_ADDR_W];

	logic [31:0] lfsr;
	logic        rows_ready;

	pipe_top #(.WIDTH(TB_WIDTH), .REG_ADDR_W(TB_ADDR_W)) u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.issue    (issue),
		.op       (op),
		.rd       (rd),
		.ra       (ra),
		.rb       (rb),
		.imm      (imm),
		.use_imm  (use_imm),
		.res_valid(res_valid),
		.res_rd   (res_rd),
		.res_data (res_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////
	// Reference and stimulus helpers
	////////////////////////////////////////

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// One LFSR step per bit, first bit ends up most significant
	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// ALU behavior, shift amount is the low five bits of B
	function automatic logic [TB_WIDTH-1:0] alu_ref(input alu_op_e o,
			input logic [TB_WIDTH-1:0] a, input logic [TB_WIDTH-1:0] b);
		case (o)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLL:  return a << b[4:0];
			OP_SRL:  return a >> b[4:0];
			default: return '0;
		endcase
	endfunction

	task automatic row(input logic iss, input alu_op_e o, input logic [TB_ADDR_W-1:0] d,
			input logic [TB_ADDR_W-1:0] a, input logic [TB_ADDR_W-1:0] b,
			input logic [TB_WIDTH-1:0] im, input logic ui, input string name);
		t_issue.push_back(iss);
		t_op.push_back(o);
		t_rd.push_back(d);
		t_ra.push_back(a);
		t_rb.push_back(b);
		t_imm.push_back(im);
		t_use_imm.push_back(ui);
		t_name.push_back(name);
	endtask

	task automatic bubbles(input int n, input string name);
		for (int i = 0; i < n; i++)
			row(1'b0, OP_ADD, 5'd0, 5'd0, 5'd0, '0, 1'b0, name);
	endtask

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic expect_valid(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s: res_valid expected %0b, actual %0b", name, exp, act);
			$display("Verification failed");
			$fatal(1, "res_valid mismatch");
		end
	endtask

	task automatic compare_index(input string name, input logic [TB_ADDR_W-1:0] exp,
			input logic [TB_ADDR_W-1:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s: res_rd expected %0d, actual %0d", name, exp, act);
			$display("Verification failed");
			$fatal(1, "res_rd mismatch");
		end
	endtask

	task automatic check_data(input string name, input logic [TB_WIDTH-1:0] exp,
			input logic [TB_WIDTH-1:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s: res_data expected %h, actual %h", name, exp, act);
			$display("Verification failed");
			$fatal(1, "res_data mismatch");
		end
	endtask

	// Drive one table entry, then check the entry issued two cycles earlier
	task automatic run_cycle(input int i);
		logic [TB_WIDTH-1:0] a;
		logic [TB_WIDTH-1:0] b;
		logic [TB_WIDTH-1:0] res;
		logic                v;
		logic [TB_ADDR_W-1:0] d;
		logic [TB_WIDTH-1:0] x;
		string               name;
		@(posedge clk);
		issue   <= t_issue[i];
		op      <= t_op[i];
		rd      <= t_rd[i];
		ra      <= t_ra[i];
		rb      <= t_rb[i];
		imm     <= t_imm[i];
		use_imm <= t_use_imm[i];
		if (t_issue[i]) begin
			a   = model[t_ra[i]];
			b   = t_use_imm[i] ? t_imm[i] : model[t_rb[i]];
			res = alu_ref(t_op[i], a, b);
			// r0 stays zero in the model
			if (t_rd[i] != '0)
				model[t_rd[i]] = res;
			exp_valid_q.push_back(1'b1);
			exp_rd_q.push_back(t_rd[i]);
			exp_data_q.push_back(res);
		end else begin
			exp_valid_q.push_back(1'b0);
			exp_rd_q.push_back('0);
			exp_data_q.push_back('0);
		end
		exp_name_q.push_back(t_name[i]);
		@(negedge clk);
		if (exp_valid_q.size() > 2) begin
			v    = exp_valid_q.pop_front();
			d    = exp_rd_q.pop_front();
			x    = exp_data_q.pop_front();
			name = exp_name_q.pop_front();
			expect_valid(name, v, res_valid);
			if (v) begin
				compare_index(name, d, res_rd);
				check_data(name, x, res_data);
			end
		end
	endtask

	// Random rows, three bit register indices to provoke hazards
	task automatic fill_random(input int n);
		logic [31:0]          v;
		logic                 iss;
		alu_op_e              o;
		logic [TB_ADDR_W-1:0] d;
		logic [TB_ADDR_W-1:0] a;
		logic [TB_ADDR_W-1:0] b;
		logic [TB_WIDTH-1:0]  im;
		for (int i = 0; i < n; i++) begin
			take_bits(2, v);
			iss = (v[1:0] != 2'b00);
			take_bits(3, v);
			o = alu_op_e'(3'(v % 7));
			take_bits(3, v);
			d = {2'b00, v[2:0]};
			take_bits(3, v);
			a = {2'b00, v[2:0]};
			take_bits(3, v);
			b = {2'b00, v[2:0]};
			take_bits(12, v);
			im = {{20{v[11]}}, v[11:0]};
			take_bits(1, v);
			row(iss, o, d, a, b, im, v[0], "lfsr_stream");
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		rst_n      = 1'b0;
		issue      = 1'b0;
		op         = OP_ADD;
		rd         = '0;
		ra         = '0;
		rb         = '0;
		imm        = '0;
		use_imm    = 1'b0;
		lfsr       = LFSR_SEED;
		rows_ready = 1'b0;
		for (int i = 0; i < (1 << TB_ADDR_W); i++)
			model[i] = '0;

		// Idle after reset
		bubbles(4, "idle_after_reset");
		// Immediate loads from r0
		row(1'b1, OP_ADD, 5'd1, 5'd0, 5'd0, 32'h0000_1234, 1'b1, "load_r1");
		row(1'b1, OP_ADD, 5'd2, 5'd0, 5'd0, 32'hFFFF_FF00, 1'b1, "load_r2");
		row(1'b1, OP_ADD, 5'd3, 5'd0, 5'd0, 32'h0000_0005, 1'b1, "load_r3");
		row(1'b1, OP_OR,  5'd4, 5'd0, 5'd0, 32'h8000_0001, 1'b1, "load_r4");
		row(1'b1, OP_XOR, 5'd5, 5'd0, 5'd0, 32'h0F0F_0F0F, 1'b1, "load_r5");
		bubbles(2, "load_gap");
		// Register file reads, every opcode
		row(1'b1, OP_ADD, 5'd6,  5'd1, 5'd2, '0, 1'b0, "rf_add");
		bubbles(2, "rf_gap");
		row(1'b1, OP_SUB, 5'd7,  5'd1, 5'd2, '0, 1'b0, "rf_sub");
		bubbles(2, "rf_gap");
		row(1'b1, OP_AND, 5'd8,  5'd4, 5'd5, '0, 1'b0, "rf_and");
		bubbles(2, "rf_gap");
		row(1'b1, OP_OR,  5'd9,  5'd4, 5'd5, '0, 1'b0, "rf_or");
		bubbles(2, "rf_gap");
		row(1'b1, OP_XOR, 5'd10, 5'd4, 5'd5, '0, 1'b0, "rf_xor");
		bubbles(2, "rf_gap");
		row(1'b1, OP_SLL, 5'd11, 5'd1, 5'd3, '0, 1'b0, "rf_sll");
		bubbles(2, "rf_gap");
		row(1'b1, OP_SRL, 5'd12, 5'd4, 5'd3, '0, 1'b0, "rf_srl");
		bubbles(2, "rf_gap");
		// EX forwarding on A, then on B
		row(1'b1, OP_ADD, 5'd13, 5'd1,  5'd3,  '0, 1'b0, "ex_fwd_src");
		row(1'b1, OP_ADD, 5'd14, 5'd13, 5'd2,  '0, 1'b0, "ex_fwd_a");
		row(1'b1, OP_XOR, 5'd15, 5'd5,  5'd14, '0, 1'b0, "ex_fwd_b");
		bubbles(2, "ex_gap");
		// WB forwarding on A
		row(1'b1, OP_SUB, 5'd16, 5'd2,  5'd3, '0, 1'b0, "wb_fwd_src");
		row(1'b1, OP_OR,  5'd17, 5'd1,  5'd1, '0, 1'b0, "wb_fwd_spacer");
		row(1'b1, OP_ADD, 5'd18, 5'd16, 5'd4, '0, 1'b0, "wb_fwd_a");
		bubbles(2, "wb_gap");
		// WB forwarding on B
		row(1'b1, OP_XOR, 5'd22, 5'd1, 5'd2,  '0, 1'b0, "wb_fwd_src_b");
		row(1'b1, OP_ADD, 5'd23, 5'd0, 5'd0,  32'h0000_0077, 1'b1, "wb_fwd_spacer_b");
		row(1'b1, OP_SUB, 5'd24, 5'd4, 5'd22, '0, 1'b0, "wb_fwd_b");
		bubbles(2, "wb_gap");
		// Both stages hold r20, EX must win
		row(1'b1, OP_ADD, 5'd20, 5'd1,  5'd0, 32'h0000_0010, 1'b1, "prio_old");
		row(1'b1, OP_ADD, 5'd20, 5'd20, 5'd0, 32'h0000_0001, 1'b1, "prio_new");
		row(1'b1, OP_SLL, 5'd21, 5'd20, 5'd3, '0, 1'b0, "prio_ex_wins");
		bubbles(2, "prio_gap");
		// r0 as destination, then r0 read right after and later
		row(1'b1, OP_ADD, 5'd0,  5'd1, 5'd0, 32'h0000_0055, 1'b1, "r0_write");
		row(1'b1, OP_ADD, 5'd25, 5'd0, 5'd0, '0, 1'b0, "r0_dep_ex");
		row(1'b1, OP_OR,  5'd26, 5'd0, 5'd1, '0, 1'b0, "r0_dep_wb");
		bubbles(3, "r0_gap");
		row(1'b1, OP_ADD, 5'd27, 5'd0, 5'd0, '0, 1'b0, "r0_read_rf");
		bubbles(2, "r0_gap");
		fill_random(RANDOM_ROWS);
		// Flush the last two results
		bubbles(2, "drain");
		rows_ready = 1'b1;

		// Pipeline is empty after reset
		repeat (2) begin
			exp_valid_q.push_back(1'b0);
			exp_rd_q.push_back('0);
			exp_data_q.push_back('0);
			exp_name_q.push_back("reset");
		end

		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		for (int i = 0; i < t_issue.size(); i++)
			run_cycle(i);

		$display("Verification passed");
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		longint limit;
		wait (rows_ready);
		limit = longint'(RESET_CYCLES + t_issue.size() + MARGIN_CYCLES) * CLK_PERIOD;
		#(limit);
		$display("Timeout: the run did not finish within %0d ns", limit);
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* sources.f */
verilog/core_pkg.sv
verilog/fwd_if.sv
verilog/reg_file.sv
verilog/fwd_select.sv
verilog/operand_muxes.sv
verilog/exec_unit.sv
verilog/pipe_top.sv
testbench/tb_pipe.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the pipeline slice testbench with Verilator and run it.
# The exit status is the simulator's own: nonzero on any $fatal.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_pipe \
	-Mdir obj_dir \
	-o tb_pipe_sim \
	-f sources.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/tb_pipe_sim
run_status=$?
if [ $run_status -ne 0 ]; then
	echo "Simulation failed with status $run_status"
	exit $run_status
fi

echo "Simulation finished with status 0"
exit 0
